// ==== common/rv_core_pkg.sv ====
package rv_core_pkg;

    // datapath and register file widths
    localparam int xlen       = 64;
    localparam int instr_w    = 32;
    localparam int reg_addr_w = 5;
    localparam int reg_count  = 2 ** reg_addr_w;

    // decoded operations, op_nop covers anything unsupported
    typedef enum logic [3:0] {
        op_nop,
        op_addi,
        op_add,
        op_sub,
        op_addw,
        op_lui,
        op_ld,
        op_lw,
        op_lwu,
        op_lh,
        op_sd,
        op_ebreak
    } op_e;

    // write-back width handling
    typedef enum logic [1:0] {
        ext_full,    // ld, alu ops
        ext_sext_w,  // lw, addw
        ext_zext_w,  // lwu
        ext_sext_h   // lh
    } ext_e;

    // issue register contents, decode to execute
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        op_e                   op;
        logic [reg_addr_w-1:0] rd;
        logic [xlen-1:0]       a;
        logic [xlen-1:0]       b;           // rs2 or immediate
        logic [xlen-1:0]       store_data;
        logic                  wen;
    } ex_req_t;

    // execute result, execute to memory
    typedef struct packed {
        logic                  valid;
        logic [xlen-1:0]       pc;
        op_e                   op;
        logic [reg_addr_w-1:0] rd;
        logic                  wen;
        logic [xlen-1:0]       res;         // alu result or address
        logic [xlen-1:0]       store_data;
    } mem_req_t;

endpackage

// ==== common/wb_if.sv ====
interface wb_if;

    logic                                valid;
    logic [rv_core_pkg::xlen-1:0]        pc;
    logic [rv_core_pkg::reg_addr_w-1:0]  rd;
    logic                                wen;
    logic [rv_core_pkg::xlen-1:0]        alu_res;
    logic [rv_core_pkg::xlen-1:0]        load_data;   // already shifted down to bit 0
    logic                                is_load;
    rv_core_pkg::ext_e                   ext;
    logic                                is_ebreak;

    // memory stage side
    modport src (
        output valid, pc, rd, wen, alu_res, load_data, is_load, ext, is_ebreak
    );

    // write-back side
    modport dst (
        input valid, pc, rd, wen, alu_res, load_data, is_load, ext, is_ebreak
    );

endinterface

// ==== verilog/id_stage.sv ====
module id_stage #(
    parameter int iq_depth = 4
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [rv_core_pkg::instr_w-1:0]     instr_data,
    input  logic [rv_core_pkg::xlen-1:0]        instr_pc,
    output logic                                instr_credit,
    output logic [rv_core_pkg::reg_addr_w-1:0]  rs1_addr,
    output logic [rv_core_pkg::reg_addr_w-1:0]  rs2_addr,
    input  logic [rv_core_pkg::xlen-1:0]        rs1_data,
    input  logic [rv_core_pkg::xlen-1:0]        rs2_data,
    input  logic                                release_valid,
    input  logic [rv_core_pkg::reg_addr_w-1:0]  release_rd,
    input  logic                                halted,
    output rv_core_pkg::ex_req_t                ex_req
);

    localparam int ptr_w = (iq_depth > 1) ? $clog2(iq_depth) : 1;
    localparam int cnt_w = $clog2(iq_depth + 1);

    logic [rv_core_pkg::instr_w-1:0]    iq_instr [iq_depth];
    logic [rv_core_pkg::xlen-1:0]       iq_pc [iq_depth];
    logic [ptr_w-1:0]                   wr_ptr;
    logic [ptr_w-1:0]                   rd_ptr;
    logic [cnt_w-1:0]                   iq_count;
    logic                               push;
    logic                               pop;
    logic                               stopped;   // ebreak already issued

    logic [rv_core_pkg::instr_w-1:0]    head;
    rv_core_pkg::op_e                   op;
    logic [rv_core_pkg::reg_addr_w-1:0] rd;
    logic                               uses_rs1;
    logic                               uses_rs2;
    logic                               wen;
    logic [rv_core_pkg::xlen-1:0]       imm;

    logic [rv_core_pkg::reg_count-1:0]  busy;
    logic [rv_core_pkg::reg_count-1:0]  pending;   // busy less this cycle's release
    logic [rv_core_pkg::reg_count-1:0]  set_mask;
    logic                               hazard;

    assign head     = iq_instr[rd_ptr];
    assign rd       = head[11:7];
    assign rs1_addr = head[19:15];
    assign rs2_addr = head[24:20];

    // decoder
    always_comb begin
        op       = rv_core_pkg::op_nop;
        uses_rs1 = 1'b0;
        uses_rs2 = 1'b0;
        wen      = 1'b0;
        imm      = {{(rv_core_pkg::xlen - 12){head[31]}}, head[31:20]};  // i-type
        case (head[6:0])
            7'b0010011: if (head[14:12] == 3'b000) begin
                op       = rv_core_pkg::op_addi;
                uses_rs1 = 1'b1;
                wen      = 1'b1;
            end
            7'b0110011: if (head[14:12] == 3'b000) begin
                if (head[31:25] == 7'b0000000) op = rv_core_pkg::op_add;
                if (head[31:25] == 7'b0100000) op = rv_core_pkg::op_sub;
                uses_rs1 = (op != rv_core_pkg::op_nop);
                uses_rs2 = (op != rv_core_pkg::op_nop);
                wen      = (op != rv_core_pkg::op_nop);
            end
            7'b0111011: if (head[14:12] == 3'b000 && head[31:25] == 7'b0000000) begin
                op       = rv_core_pkg::op_addw;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                wen      = 1'b1;
            end
            7'b0110111: begin
                op  = rv_core_pkg::op_lui;
                wen = 1'b1;
                imm = {{(rv_core_pkg::xlen - 20){head[31]}}, head[31:12]};  // shifted in ex
            end
            7'b0000011: begin
                case (head[14:12])
                    3'b011:  op = rv_core_pkg::op_ld;
                    3'b010:  op = rv_core_pkg::op_lw;
                    3'b110:  op = rv_core_pkg::op_lwu;
                    3'b001:  op = rv_core_pkg::op_lh;
                    default: op = rv_core_pkg::op_nop;
                endcase
                uses_rs1 = (op != rv_core_pkg::op_nop);
                wen      = (op != rv_core_pkg::op_nop);
            end
            7'b0100011: if (head[14:12] == 3'b011) begin
                op       = rv_core_pkg::op_sd;
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm      = {{(rv_core_pkg::xlen - 12){head[31]}}, head[31:25], head[11:7]};
            end
            7'b1110011: if (head == 32'h0010_0073) op = rv_core_pkg::op_ebreak;
            default: ;
        endcase
    end

    // scoreboard, a release this cycle already frees the register
    assign pending  = busy & ~(release_valid ? (rv_core_pkg::reg_count'(1) << release_rd) : '0);
    assign hazard   = (uses_rs1 && pending[rs1_addr]) ||
                      (uses_rs2 && pending[rs2_addr]) ||
                      (wen && pending[rd]);
    assign pop      = (iq_count != '0) && !hazard && !halted && !stopped;
    assign set_mask = (pop && wen && rd != '0) ? (rv_core_pkg::reg_count'(1) << rd) : '0;
    assign push     = instr_valid && (iq_count != cnt_w'(iq_depth));  // no credit, dropped

    always_ff @(posedge clk) begin
        if (push) begin
            iq_instr[wr_ptr] <= instr_data;
            iq_pc[wr_ptr]    <= instr_pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            iq_count     <= '0;
            instr_credit <= 1'b0;
            busy         <= '0;
            stopped      <= 1'b0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == ptr_w'(iq_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == ptr_w'(iq_depth - 1)) ? '0 : rd_ptr + 1'b1;
            iq_count     <= iq_count + cnt_w'(push) - cnt_w'(pop);
            instr_credit <= pop;           // one credit per entry leaving
            busy         <= pending | set_mask;
            if (pop && op == rv_core_pkg::op_ebreak) stopped <= 1'b1;
        end
    end

    // issue register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_req.valid <= 1'b0;
        end else begin
            ex_req.valid      <= pop;
            ex_req.pc         <= iq_pc[rd_ptr];
            ex_req.op         <= op;
            ex_req.rd         <= rd;
            ex_req.a          <= rs1_data;
            ex_req.b          <= (uses_rs2 && op != rv_core_pkg::op_sd) ? rs2_data : imm;
            ex_req.store_data <= rs2_data;
            ex_req.wen        <= wen;
        end
    end

endmodule

// ==== verilog/ex_stage.sv ====
module ex_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::ex_req_t  ex_req,
    output rv_core_pkg::mem_req_t mem_req
);

    logic [rv_core_pkg::xlen-1:0] alu_res;
    logic [31:0]                  sum_w;     // low word sum for addw

    assign sum_w = ex_req.a[31:0] + ex_req.b[31:0];

    always_comb begin
        case (ex_req.op)
            rv_core_pkg::op_addi,
            rv_core_pkg::op_add: begin
                alu_res = ex_req.a + ex_req.b;
            end
            rv_core_pkg::op_sub: begin
                alu_res = ex_req.a - ex_req.b;
            end
            rv_core_pkg::op_addw: begin
                alu_res = {{(rv_core_pkg::xlen - 32){1'b0}}, sum_w};  // widened in write-back
            end
            rv_core_pkg::op_lui: begin
                alu_res = ex_req.b << 12;
            end
            // address generation, base plus offset
            rv_core_pkg::op_ld,
            rv_core_pkg::op_lw,
            rv_core_pkg::op_lwu,
            rv_core_pkg::op_lh,
            rv_core_pkg::op_sd: begin
                alu_res = ex_req.a + ex_req.b;
            end
            default: begin
                alu_res = '0;   // nop, ebreak
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req.valid <= 1'b0;
        end else begin
            mem_req.valid      <= ex_req.valid;
            mem_req.pc         <= ex_req.pc;
            mem_req.op         <= ex_req.op;
            mem_req.rd         <= ex_req.rd;
            mem_req.wen        <= ex_req.wen;
            mem_req.res        <= alu_res;
            mem_req.store_data <= ex_req.store_data;
        end
    end

endmodule

// ==== verilog/mem_stage.sv ====
module mem_stage #(
    parameter int dmem_words = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_core_pkg::mem_req_t mem_req,
    wb_if.src                     wb
);

    localparam int idx_w = (dmem_words > 1) ? $clog2(dmem_words) : 1;

    logic [rv_core_pkg::xlen-1:0] dmem [dmem_words];
    logic [idx_w-1:0]             idx;        // doubleword index
    logic [rv_core_pkg::xlen-1:0] rdata;
    logic [rv_core_pkg::xlen-1:0] load_data;
    logic                         is_load;
    rv_core_pkg::ext_e            ext;

    assign idx       = mem_req.res[3 +: idx_w];
    assign rdata     = dmem[idx];
    assign load_data = rdata >> {mem_req.res[2:0], 3'b000};  // word or half down to bit 0

    // doubleword stores only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < dmem_words; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_req.valid && mem_req.op == rv_core_pkg::op_sd) begin
            dmem[idx] <= mem_req.store_data;
        end
    end

    always_comb begin
        is_load = 1'b0;
        ext     = rv_core_pkg::ext_full;
        case (mem_req.op)
            rv_core_pkg::op_ld:   is_load = 1'b1;
            rv_core_pkg::op_lw: begin
                is_load = 1'b1;
                ext     = rv_core_pkg::ext_sext_w;
            end
            rv_core_pkg::op_lwu: begin
                is_load = 1'b1;
                ext     = rv_core_pkg::ext_zext_w;
            end
            rv_core_pkg::op_lh: begin
                is_load = 1'b1;
                ext     = rv_core_pkg::ext_sext_h;
            end
            rv_core_pkg::op_addw: ext = rv_core_pkg::ext_sext_w;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid     <= mem_req.valid;
            wb.pc        <= mem_req.pc;
            wb.rd        <= mem_req.rd;
            wb.wen       <= mem_req.wen;
            wb.alu_res   <= mem_req.res;
            wb.load_data <= load_data;
            wb.is_load   <= is_load;
            wb.ext       <= ext;
            wb.is_ebreak <= (mem_req.op == rv_core_pkg::op_ebreak);
        end
    end

endmodule

// ==== verilog/wb_stage.sv ====
module wb_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    wb_if.dst                                   wb,
    input  logic [rv_core_pkg::reg_addr_w-1:0]  rs1_addr,
    input  logic [rv_core_pkg::reg_addr_w-1:0]  rs2_addr,
    output logic [rv_core_pkg::xlen-1:0]        rs1_data,
    output logic [rv_core_pkg::xlen-1:0]        rs2_data,
    output logic                                release_valid,
    output logic [rv_core_pkg::reg_addr_w-1:0]  release_rd,
    output logic                                retire_valid,
    output logic [rv_core_pkg::xlen-1:0]        retire_pc,
    output logic                                retire_wen,
    output logic [rv_core_pkg::reg_addr_w-1:0]  retire_rd,
    output logic [rv_core_pkg::xlen-1:0]        retire_data,
    output logic                                halted
);

    logic [rv_core_pkg::xlen-1:0] regs [rv_core_pkg::reg_count];
    logic [rv_core_pkg::xlen-1:0] sel_data;
    logic [rv_core_pkg::xlen-1:0] wdata;
    logic                         wr_en;

    // load result or alu result
    assign sel_data = wb.is_load ? wb.load_data : wb.alu_res;

    always_comb begin
        case (wb.ext)
            rv_core_pkg::ext_sext_w: wdata = {{32{sel_data[31]}}, sel_data[31:0]};
            rv_core_pkg::ext_zext_w: wdata = {32'b0, sel_data[31:0]};
            rv_core_pkg::ext_sext_h: wdata = {{48{sel_data[15]}}, sel_data[15:0]};
            default:                 wdata = sel_data;
        endcase
    end

    assign wr_en = wb.valid && wb.wen && (wb.rd != '0);  // x0 stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_core_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wb.rd] <= wdata;
        end
    end

    // decode reads the current state
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_valid  <= 1'b0;
            release_valid <= 1'b0;
            halted        <= 1'b0;
        end else begin
            retire_valid  <= wb.valid;
            retire_pc     <= wb.pc;      // delayed pc copy
            retire_wen    <= wr_en;
            retire_rd     <= wb.rd;
            retire_data   <= wdata;
            release_valid <= wr_en;      // frees the scoreboard bit
            release_rd    <= wb.rd;
            if (wb.valid && wb.is_ebreak) halted <= 1'b1;  // sticky until reset
        end
    end

endmodule

// ==== verilog/rv_core.sv ====
module rv_core #(
    parameter int iq_depth   = 4,
    parameter int dmem_words = 64
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                instr_valid,
    input  logic [rv_core_pkg::instr_w-1:0]     instr_data,
    input  logic [rv_core_pkg::xlen-1:0]        instr_pc,
    output logic                                instr_credit,
    output logic                                retire_valid,
    output logic [rv_core_pkg::xlen-1:0]        retire_pc,
    output logic                                retire_wen,
    output logic [rv_core_pkg::reg_addr_w-1:0]  retire_rd,
    output logic [rv_core_pkg::xlen-1:0]        retire_data,
    output logic                                halted
);

    rv_core_pkg::ex_req_t               ex_req;
    rv_core_pkg::mem_req_t              mem_req;
    logic [rv_core_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_core_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_core_pkg::xlen-1:0]       rs1_data;
    logic [rv_core_pkg::xlen-1:0]       rs2_data;
    logic                               release_valid;
    logic [rv_core_pkg::reg_addr_w-1:0] release_rd;

    wb_if wb_bus ();   // memory to write-back bundle

    id_stage #(
        .iq_depth(iq_depth)
    ) u_id (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr_data   (instr_data),
        .instr_pc     (instr_pc),
        .instr_credit (instr_credit),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .release_valid(release_valid),
        .release_rd   (release_rd),
        .halted       (halted),
        .ex_req       (ex_req)
    );

    ex_stage u_ex (
        .clk    (clk),
        .rst_n  (rst_n),
        .ex_req (ex_req),
        .mem_req(mem_req)
    );

    mem_stage #(
        .dmem_words(dmem_words)
    ) u_mem (
        .clk    (clk),
        .rst_n  (rst_n),
        .mem_req(mem_req),
        .wb     (wb_bus.src)
    );

    wb_stage u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb           (wb_bus.dst),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .release_valid(release_valid),
        .release_rd   (release_rd),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_wen   (retire_wen),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .halted       (halted)
    );

endmodule

// ==== dv/rv_core_assertions.sv ====
module rv_core_assertions #(
    parameter int iq_depth = 4
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                instr_valid,
    input logic                                instr_credit,
    input logic                                retire_valid,
    input logic                                retire_wen,
    input logic [rv_core_pkg::reg_addr_w-1:0]  retire_rd,
    input logic                                halted
);

    int in_flight;   // accepted, credit not yet back

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(instr_valid) - int'(instr_credit);
        end
    end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n) halted |=> halted)
        else $error("halted fell without a reset");

    // x0 is never reported as written
    x0_not_written: assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> !(retire_wen && retire_rd == '0))
        else $error("retire reports a write to x0");

    credit_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
        instr_credit |-> in_flight > 0)
        else $error("credit returned with the queue empty");

    // a send without a credit is dropped by the queue
    send_with_credit: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> in_flight < iq_depth)
        else $error("instruction sent with no credit left");

endmodule

// ==== dv/tb_rv_core.sv ====
module tb_rv_core;

    localparam int iq_depth   = 4;
    localparam int dmem_words = 64;

    typedef struct packed {
        logic [rv_core_pkg::xlen-1:0]       pc;
        logic                               writer;   // op has a destination
        logic                               wen;
        logic [rv_core_pkg::reg_addr_w-1:0] rd;
        logic [rv_core_pkg::xlen-1:0]       data;
    } retire_rec_t;

    logic                               clk;
    logic                               rst_n;
    logic                               instr_valid;
    logic [rv_core_pkg::instr_w-1:0]    instr_data;
    logic [rv_core_pkg::xlen-1:0]       instr_pc;
    logic                               instr_credit;
    logic                               retire_valid;
    logic [rv_core_pkg::xlen-1:0]       retire_pc;
    logic                               retire_wen;
    logic [rv_core_pkg::reg_addr_w-1:0] retire_rd;
    logic [rv_core_pkg::xlen-1:0]       retire_data;
    logic                               halted;

    logic [rv_core_pkg::xlen-1:0] mregs [rv_core_pkg::reg_count];  // model state
    logic [rv_core_pkg::xlen-1:0] mmem [dmem_words];
    retire_rec_t                  expq [$];
    logic [rv_core_pkg::xlen-1:0] next_pc = 64'h1000;
    logic                         halt_sent = 1'b0;
    int                           sent = 0;
    int                           returned = 0;
    int                           cycles = 0;
    int                           checks = 0;
    int                           errors = 0;

    rv_core #(
        .iq_depth  (iq_depth),
        .dmem_words(dmem_words)
    ) DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr_data  (instr_data),
        .instr_pc    (instr_pc),
        .instr_credit(instr_credit),
        .retire_valid(retire_valid),
        .retire_pc   (retire_pc),
        .retire_wen  (retire_wen),
        .retire_rd   (retire_rd),
        .retire_data (retire_data),
        .halted      (halted)
    );

    bind rv_core rv_core_assertions #(.iq_depth(iq_depth)) u_assert (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr_credit(instr_credit),
        .retire_valid(retire_valid), .retire_wen(retire_wen), .retire_rd(retire_rd),
        .halted(halted)
    );

    always #4 clk = ~clk;

    task automatic check_data(input string name, input logic [rv_core_pkg::xlen-1:0] exp,
                              input logic [rv_core_pkg::xlen-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED %s: expected %h, got %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_rd(input logic [rv_core_pkg::reg_addr_w-1:0] exp,
                            input logic [rv_core_pkg::reg_addr_w-1:0] act);
        checks++;
        if (act !== exp) begin
            $display("FAILED retire_rd: expected %h, got %h", exp, act);
            errors++;
        end
    endtask

    task automatic check_wen(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAILED retire_wen: expected %h, got %h", exp, act);
            errors++;
        end
    endtask

    task automatic check_halted(input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("FAILED halted: expected %h, got %h", exp, act);
            errors++;
        end
    endtask

    function automatic logic [19:0] rnd();
        return 20'($urandom);
    endfunction

    // waits for a credit, then holds instr_valid for one edge
    task automatic send(input logic [31:0] ins, input logic [rv_core_pkg::xlen-1:0] pc);
        while (iq_depth - sent + returned <= 0) begin
            @(posedge clk);
            #1;
        end
        instr_valid = 1'b1;
        instr_data  = ins;
        instr_pc    = pc;
        sent++;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    // encode, run through the model, queue the expected retire and send
    task automatic exec(input rv_core_pkg::op_e op, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2, input logic [19:0] imm);
        logic [31:0]                  ins;
        logic [rv_core_pkg::xlen-1:0] a;
        logic [rv_core_pkg::xlen-1:0] b;
        logic [rv_core_pkg::xlen-1:0] sx;
        logic [rv_core_pkg::xlen-1:0] addr;
        logic [rv_core_pkg::xlen-1:0] dw;
        logic [31:0]                  w;
        retire_rec_t                  rec;
        a        = mregs[rs1];
        b        = mregs[rs2];
        sx       = {{52{imm[11]}}, imm[11:0]};
        addr     = a + sx;
        dw       = mmem[addr[8:3]] >> {addr[2:0], 3'b000};  // little endian
        w        = a[31:0] + b[31:0];
        rec.data = '0;
        ins      = 32'h0010_0073;   // ebreak
        case (op)
            rv_core_pkg::op_addi: begin
                ins      = {imm[11:0], rs1, 3'b000, rd, 7'h13};
                rec.data = a + sx;
            end
            rv_core_pkg::op_add: begin
                ins      = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
                rec.data = a + b;
            end
            rv_core_pkg::op_sub: begin
                ins      = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
                rec.data = a - b;
            end
            rv_core_pkg::op_addw: begin
                ins      = {7'h00, rs2, rs1, 3'b000, rd, 7'h3b};
                rec.data = {{32{w[31]}}, w};
            end
            rv_core_pkg::op_lui: begin
                ins      = {imm, rd, 7'h37};
                rec.data = {{32{imm[19]}}, imm, 12'h000};
            end
            rv_core_pkg::op_ld: begin
                ins      = {imm[11:0], rs1, 3'b011, rd, 7'h03};
                rec.data = dw;
            end
            rv_core_pkg::op_lw: begin
                ins      = {imm[11:0], rs1, 3'b010, rd, 7'h03};
                rec.data = {{32{dw[31]}}, dw[31:0]};
            end
            rv_core_pkg::op_lwu: begin
                ins      = {imm[11:0], rs1, 3'b110, rd, 7'h03};
                rec.data = {32'h0, dw[31:0]};
            end
            rv_core_pkg::op_lh: begin
                ins      = {imm[11:0], rs1, 3'b001, rd, 7'h03};
                rec.data = {{48{dw[15]}}, dw[15:0]};
            end
            rv_core_pkg::op_sd: begin
                ins = {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'h23};
            end
            default: ;
        endcase
        rec.pc     = next_pc;
        rec.writer = (op != rv_core_pkg::op_sd) && (op != rv_core_pkg::op_ebreak);
        rec.wen    = rec.writer && (rd != 5'd0);
        rec.rd     = rd;
        if (!halt_sent) begin   // nothing behind ebreak takes effect
            if (rec.wen) mregs[rd] = rec.data;
            if (op == rv_core_pkg::op_sd) mmem[addr[8:3]] = b;
            expq.push_back(rec);
        end
        if (op == rv_core_pkg::op_ebreak) halt_sent = 1'b1;
        send(ins, next_pc);
        next_pc = next_pc + 64'd4;
    endtask

    task automatic drain();
        while (expq.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic test_arith();
        exec(rv_core_pkg::op_addi, 5'd1, 5'd0, 5'd0, rnd());
        exec(rv_core_pkg::op_addi, 5'd2, 5'd0, 5'd0, rnd());
        exec(rv_core_pkg::op_lui, 5'd3, 5'd0, 5'd0, rnd());
        exec(rv_core_pkg::op_add, 5'd4, 5'd1, 5'd3, 20'h0);
        exec(rv_core_pkg::op_sub, 5'd5, 5'd4, 5'd2, 20'h0);
        exec(rv_core_pkg::op_addw, 5'd6, 5'd3, 5'd5, 20'h0);
        exec(rv_core_pkg::op_lui, 5'd7, 5'd0, 5'd0, 20'h7ffff);
        exec(rv_core_pkg::op_lui, 5'd8, 5'd0, 5'd0, 20'h00001);
        exec(rv_core_pkg::op_addw, 5'd9, 5'd7, 5'd8, 20'h0);   // carries into bit 31
        drain();
    endtask

    task automatic test_loads();
        exec(rv_core_pkg::op_addi, 5'd10, 5'd0, 5'd0, 20'h00100);  // base address
        exec(rv_core_pkg::op_lui, 5'd11, 5'd0, 5'd0, 20'h80008);
        exec(rv_core_pkg::op_addi, 5'd11, 5'd11, 5'd0, 20'h00123);
        exec(rv_core_pkg::op_lui, 5'd12, 5'd0, 5'd0, 20'h12345);
        exec(rv_core_pkg::op_addi, 5'd12, 5'd12, 5'd0, 20'h00678);
        exec(rv_core_pkg::op_sd, 5'd0, 5'd10, 5'd11, 20'h00000);
        exec(rv_core_pkg::op_sd, 5'd0, 5'd10, 5'd12, 20'h00008);
        exec(rv_core_pkg::op_sd, 5'd0, 5'd10, 5'd2, 20'h00010);
        exec(rv_core_pkg::op_ld, 5'd13, 5'd10, 5'd0, 20'h00000);
        exec(rv_core_pkg::op_lw, 5'd14, 5'd10, 5'd0, 20'h00000);
        exec(rv_core_pkg::op_lwu, 5'd15, 5'd10, 5'd0, 20'h00000);
        exec(rv_core_pkg::op_lh, 5'd16, 5'd10, 5'd0, 20'h00000);
        exec(rv_core_pkg::op_lh, 5'd17, 5'd10, 5'd0, 20'h00002);
        exec(rv_core_pkg::op_lw, 5'd18, 5'd10, 5'd0, 20'h00004);
        exec(rv_core_pkg::op_lwu, 5'd19, 5'd10, 5'd0, 20'h00004);
        exec(rv_core_pkg::op_lw, 5'd20, 5'd10, 5'd0, 20'h00008);   // sign clear
        exec(rv_core_pkg::op_lwu, 5'd21, 5'd10, 5'd0, 20'h00008);
        exec(rv_core_pkg::op_lh, 5'd22, 5'd10, 5'd0, 20'h0000a);
        exec(rv_core_pkg::op_ld, 5'd23, 5'd10, 5'd0, 20'h00008);
        exec(rv_core_pkg::op_lw, 5'd24, 5'd10, 5'd0, 20'h00010);
        exec(rv_core_pkg::op_lh, 5'd24, 5'd10, 5'd0, 20'h00016);
        drain();
    endtask

    task automatic test_x0();
        exec(rv_core_pkg::op_addi, 5'd0, 5'd1, 5'd0, 20'h00055);
        exec(rv_core_pkg::op_add, 5'd0, 5'd1, 5'd2, 20'h0);
        exec(rv_core_pkg::op_lw, 5'd0, 5'd10, 5'd0, 20'h00000);
        exec(rv_core_pkg::op_add, 5'd25, 5'd0, 5'd1, 20'h0);
        exec(rv_core_pkg::op_add, 5'd26, 5'd0, 5'd0, 20'h0);
        drain();
    endtask

    task automatic test_chains();
        exec(rv_core_pkg::op_addi, 5'd27, 5'd0, 5'd0, rnd());
        exec(rv_core_pkg::op_addi, 5'd27, 5'd27, 5'd0, rnd());
        exec(rv_core_pkg::op_add, 5'd27, 5'd27, 5'd27, 20'h0);
        exec(rv_core_pkg::op_sub, 5'd28, 5'd27, 5'd1, 20'h0);
        exec(rv_core_pkg::op_addw, 5'd28, 5'd28, 5'd27, 20'h0);
        exec(rv_core_pkg::op_sd, 5'd0, 5'd10, 5'd28, 20'h00018);
        exec(rv_core_pkg::op_ld, 5'd29, 5'd10, 5'd0, 20'h00018);
        exec(rv_core_pkg::op_add, 5'd30, 5'd29, 5'd29, 20'h0);
        for (int i = 1; i < 10; i++) begin
            exec(rv_core_pkg::op_addi, 5'(i), 5'd0, 5'd0, rnd());  // independent
        end
        drain();
    endtask

    task automatic test_credits();
        for (int i = 0; i < 16; i++) begin
            exec(rv_core_pkg::op_addi, 5'(16 + i), 5'd0, 5'd0, rnd());
        end
        drain();
        check_data("credits_returned", 64'(sent), 64'(returned));
    endtask

    task automatic test_halt();
        exec(rv_core_pkg::op_ebreak, 5'd0, 5'd0, 5'd0, 20'h0);
        exec(rv_core_pkg::op_addi, 5'd1, 5'd0, 5'd0, 20'h00011);  // stuck behind ebreak
        exec(rv_core_pkg::op_add, 5'd2, 5'd1, 5'd1, 20'h0);
        while (!halted) @(posedge clk);
        repeat (20) @(posedge clk);
        #1;
        check_halted(1'b1, halted);
        check_data("credits_returned", 64'(sent - 2), 64'(returned));
        if (expq.size() != 0) begin
            $display("ebreak or an earlier instruction never retired");
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && instr_credit) returned++;
    end

    // retire monitor, unexpected retires include anything behind ebreak
    always @(posedge clk) begin
        retire_rec_t rec;
        if (rst_n && retire_valid) begin
            if (expq.size() == 0) begin
                $display("retire with no instruction outstanding, pc %h", retire_pc);
                errors++;
            end else begin
                rec = expq.pop_front();
                check_data("retire_pc", rec.pc, retire_pc);
                check_wen(rec.wen, retire_wen);
                if (rec.writer) check_rd(rec.rd, retire_rd);
                if (rec.wen) check_data("retire_data", rec.data, retire_data);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 40 * sent + 200) begin
            $display("timeout after %0d cycles with %0d instructions sent", cycles, sent);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hc4db_0fb6));
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr_data  = '0;
        instr_pc    = '0;
        for (int i = 0; i < rv_core_pkg::reg_count; i++) mregs[i] = '0;
        for (int i = 0; i < dmem_words; i++) mmem[i] = '0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_halted(1'b0, halted);
        test_arith();
        test_loads();
        test_x0();
        test_chains();
        test_credits();
        test_halt();   // last, halt holds until reset
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== all.f ====
common/rv_core_pkg.sv
common/wb_if.sv
verilog/id_stage.sv
verilog/ex_stage.sv
verilog/mem_stage.sv
verilog/wb_stage.sv
verilog/rv_core.sv
dv/rv_core_assertions.sv
dv/tb_rv_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_rv_core

out=$(./obj_dir/Vtb_rv_core) || true
echo "$out"

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1
